//--- hw/ex_consts.svh
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// datapath widths of the execute unit

// one general register word
`define EX_WORD_W      32

// destination register number
`define EX_REGADDR_W   5

// shift amount taken from reg1
`define EX_SHAMT_W     5

// leading-bit count, 0..32 needs six bits
`define EX_CNT_W       6

// opcode field width, 28 codes used
`define EX_OP_W        5

`endif

//--- hw/ex_data_pkg.sv
`include "ex_consts.svh"

package ex_data_pkg;

    // one data word
    typedef logic [`EX_WORD_W-1:0] word_t;

    typedef logic [2*`EX_WORD_W-1:0] dword_t;      // full product or {hi, lo}

    typedef logic [`EX_REGADDR_W-1:0] reg_addr_t;  // destination register

    // result of clz / clo
    typedef logic [`EX_CNT_W-1:0] cnt_t;

endpackage

//--- hw/ex_op_pkg.sv
`include "ex_consts.svh"

package ex_op_pkg;

    // operation codes, numbered 0..27 in this order
    typedef enum logic [`EX_OP_W-1:0] {
        OP_OR,
        OP_AND,
        OP_NOR,
        OP_XOR,
        OP_SLL,       // shifts take the amount from reg1
        OP_SRL,
        OP_SRA,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_CLZ,
        OP_CLO,
        OP_MOVZ,
        OP_MOVN,
        OP_MUL,       // low word only, hi/lo untouched
        OP_MULT,
        OP_MULTU,
        OP_MADD,      // accumulates need two cycles
        OP_MADDU,
        OP_MSUB,
        OP_MSUBU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } alu_op_e;

    // where the written data comes from
    typedef enum logic [2:0] {
        RES_ALU,
        RES_MUL,
        RES_HI,
        RES_LO,
        RES_NONE      // writes no register data
    } res_sel_e;

    typedef enum logic {
        ACC_IDLE,
        ACC_SUM       // product held, sum pending
    } acc_state_e;

endpackage

//--- hw/ex_issue.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_issue
    import ex_data_pkg::*;
    import ex_op_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      in_valid_i,
    input  alu_op_e   in_op_i,
    input  word_t     in_reg1_i,
    input  word_t     in_reg2_i,
    input  reg_addr_t in_wd_i,
    input  logic      in_wreg_i,
    input  logic      advance_i,   // current item leaves this cycle
    output logic      in_ready_o,
    output logic      iss_valid_o,
    output alu_op_e   iss_op_o,
    output res_sel_e  iss_sel_o,
    output word_t     iss_reg1_o,
    output word_t     iss_reg2_o,
    output reg_addr_t iss_wd_o,
    output logic      iss_wreg_o
);

    logic accept;

    // result class straight from the opcode
    function automatic res_sel_e classify(input alu_op_e op);
        case (op)
            OP_MUL:                                   return RES_MUL;
            OP_MFHI:                                  return RES_HI;
            OP_MFLO:                                  return RES_LO;
            OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO,
            OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU:     return RES_NONE;
            default:                                  return RES_ALU;
        endcase
    endfunction

    assign in_ready_o = !iss_valid_o || advance_i;
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            iss_valid_o <= 1'b0;
        end else if (accept) begin
            iss_valid_o <= 1'b1;
        end else if (advance_i) begin
            iss_valid_o <= 1'b0;   // drained, nothing new
        end
    end

    // payload only moves on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            iss_op_o   <= in_op_i;
            iss_sel_o  <= classify(in_op_i);
            iss_reg1_o <= in_reg1_i;
            iss_reg2_o <= in_reg2_i;
            iss_wd_o   <= in_wd_i;
            iss_wreg_o <= in_wreg_i;
        end
    end

endmodule

//--- hw/ex_alu.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_alu
    import ex_data_pkg::*;
    import ex_op_pkg::*;
(
    input  alu_op_e op_i,
    input  word_t   reg1_i,
    input  word_t   reg2_i,
    output word_t   alu_res_o,
    output logic    alu_ovf_o,
    output logic    alu_wr_ok_o   // low blocks the register write
);

    logic [`EX_SHAMT_W-1:0] shamt;
    logic                   is_sub;
    word_t                  opnd2;
    word_t                  sum;
    logic                   sum_ovf;
    cnt_t                   zeros;
    cnt_t                   ones;

    // number of zeros above the highest set bit
    function automatic cnt_t lead_zeros(input word_t v);
        cnt_t n;
        n = cnt_t'(`EX_WORD_W);
        for (int i = 0; i < `EX_WORD_W; i++) begin
            if (v[i]) begin
                n = cnt_t'(`EX_WORD_W - 1 - i);   // highest hit wins
            end
        end
        return n;
    endfunction

    assign shamt = reg1_i[`EX_SHAMT_W-1:0];

    assign is_sub = (op_i == OP_SUB) || (op_i == OP_SUBU);
    assign opnd2  = is_sub ? (~reg2_i + 1'b1) : reg2_i;
    assign sum    = reg1_i + opnd2;

    // operands of equal effective sign, result sign differs
    assign sum_ovf = (reg1_i[`EX_WORD_W-1] == (reg2_i[`EX_WORD_W-1] ^ is_sub)) &&
                     (sum[`EX_WORD_W-1] != reg1_i[`EX_WORD_W-1]);

    assign zeros = lead_zeros(reg1_i);
    assign ones  = lead_zeros(~reg1_i);   // clo is clz of the inverse

    always_comb begin
        case (op_i)
            OP_OR:   alu_res_o = reg1_i | reg2_i;
            OP_AND:  alu_res_o = reg1_i & reg2_i;
            OP_NOR:  alu_res_o = ~(reg1_i | reg2_i);
            OP_XOR:  alu_res_o = reg1_i ^ reg2_i;
            OP_SLL:  alu_res_o = reg2_i << shamt;
            OP_SRL:  alu_res_o = reg2_i >> shamt;
            OP_SRA:  alu_res_o = word_t'($signed(reg2_i) >>> shamt);   // sign fill
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: begin
                alu_res_o = sum;
            end
            OP_SLT:  alu_res_o = word_t'($signed(reg1_i) < $signed(reg2_i));
            OP_SLTU: alu_res_o = word_t'(reg1_i < reg2_i);
            OP_CLZ:  alu_res_o = word_t'(zeros);
            OP_CLO:  alu_res_o = word_t'(ones);
            OP_MOVZ, OP_MOVN: begin
                alu_res_o = reg1_i;
            end
            default: alu_res_o = '0;   // not an alu result
        endcase
    end

    // trapping forms only, addu/subu wrap silently
    assign alu_ovf_o = ((op_i == OP_ADD) || (op_i == OP_SUB)) && sum_ovf;

    always_comb begin
        case (op_i)
            OP_MOVZ: alu_wr_ok_o = (reg2_i == '0);
            OP_MOVN: alu_wr_ok_o = (reg2_i != '0);
            default: alu_wr_ok_o = !alu_ovf_o;
        endcase
    end

endmodule

//--- hw/ex_mult_acc.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_mult_acc
    import ex_data_pkg::*;
    import ex_op_pkg::*;
(
    input  logic    clk,
    input  logic    reset_i,
    input  logic    iss_valid_i,
    input  alu_op_e op_i,
    input  word_t   reg1_i,
    input  word_t   reg2_i,
    input  logic    advance_i,
    output logic    mac_done_o,   // low in the first accumulate cycle
    output word_t   mul_lo_o,
    output word_t   hi_o,
    output word_t   lo_o
);

    acc_state_e acc_state;
    dword_t     hilo;        // {hi, lo}
    dword_t     acc_tmp;     // product, negated for msub
    dword_t     opnd1_ext;
    dword_t     opnd2_ext;
    dword_t     product;
    logic       is_signed;
    logic       is_acc;
    logic       is_minus;

    assign is_signed = (op_i == OP_MUL) || (op_i == OP_MULT) ||
                       (op_i == OP_MADD) || (op_i == OP_MSUB);

    assign is_acc = (op_i == OP_MADD) || (op_i == OP_MADDU) ||
                    (op_i == OP_MSUB) || (op_i == OP_MSUBU);

    assign is_minus = (op_i == OP_MSUB) || (op_i == OP_MSUBU);

    // extend to 64 bits, the low 64 bits of the product are then exact
    assign opnd1_ext = is_signed ? {{`EX_WORD_W{reg1_i[`EX_WORD_W-1]}}, reg1_i}
                                 : {{`EX_WORD_W{1'b0}}, reg1_i};
    assign opnd2_ext = is_signed ? {{`EX_WORD_W{reg2_i[`EX_WORD_W-1]}}, reg2_i}
                                 : {{`EX_WORD_W{1'b0}}, reg2_i};
    assign product   = opnd1_ext * opnd2_ext;

    assign mul_lo_o = product[`EX_WORD_W-1:0];
    assign hi_o     = hilo[2*`EX_WORD_W-1:`EX_WORD_W];
    assign lo_o     = hilo[`EX_WORD_W-1:0];

    assign mac_done_o = !(iss_valid_i && is_acc && (acc_state == ACC_IDLE));

    // accumulate sequencing
    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc_state <= ACC_IDLE;
        end else begin
            case (acc_state)
                ACC_IDLE: begin
                    if (iss_valid_i && is_acc) begin
                        acc_state <= ACC_SUM;
                    end
                end
                ACC_SUM: begin
                    if (advance_i) begin
                        acc_state <= ACC_IDLE;   // sum committed
                    end
                end
                default: acc_state <= ACC_IDLE;
            endcase
        end
    end

    // first accumulate cycle parks the product
    always_ff @(posedge clk) begin
        if ((acc_state == ACC_IDLE) && iss_valid_i && is_acc) begin
            acc_tmp <= is_minus ? (~product + 1'b1) : product;
        end
    end

    // hi/lo only changes when the owning item leaves
    always_ff @(posedge clk) begin
        if (reset_i) begin
            hilo <= '0;
        end else if (advance_i) begin
            case (op_i)
                OP_MULT, OP_MULTU: hilo <= product;
                OP_MTHI: hilo[2*`EX_WORD_W-1:`EX_WORD_W] <= reg1_i;
                OP_MTLO: hilo[`EX_WORD_W-1:0] <= reg1_i;
                OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU: begin
                    hilo <= hilo + acc_tmp;
                end
                default: hilo <= hilo;
            endcase
        end
    end

endmodule

//--- hw/ex_writeback.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_writeback
    import ex_data_pkg::*;
    import ex_op_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      iss_valid_i,
    input  res_sel_e  iss_sel_i,
    input  reg_addr_t iss_wd_i,
    input  logic      iss_wreg_i,
    input  logic      mac_done_i,
    input  word_t     alu_res_i,
    input  logic      alu_ovf_i,
    input  logic      alu_wr_ok_i,
    input  word_t     mul_lo_i,
    input  word_t     hi_i,
    input  word_t     lo_i,
    input  logic      out_ready_i,
    output logic      advance_o,
    output logic      out_valid_o,
    output word_t     out_wdata_o,
    output reg_addr_t out_wd_o,
    output logic      out_wreg_o,
    output logic      out_ovf_o
);

    word_t wdata;
    logic  wr_ok;
    logic  is_alu;

    // output slot free or being emptied this cycle
    assign advance_o = iss_valid_i && mac_done_i && (!out_valid_o || out_ready_i);

    assign is_alu = (iss_sel_i == RES_ALU);
    assign wr_ok  = is_alu ? alu_wr_ok_i : 1'b1;

    always_comb begin
        case (iss_sel_i)
            RES_ALU: wdata = alu_res_i;
            RES_MUL: wdata = mul_lo_i;
            RES_HI:  wdata = hi_i;
            RES_LO:  wdata = lo_i;
            default: wdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_valid_o <= 1'b0;
        end else if (advance_o) begin
            out_valid_o <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (advance_o) begin
            out_wdata_o <= wdata;
            out_wd_o    <= iss_wd_i;
            out_wreg_o  <= iss_wreg_i && wr_ok;
            out_ovf_o   <= is_alu && alu_ovf_i;
        end
    end

endmodule

//--- hw/ex_top.sv
`timescale 1ns/1ps
`include "ex_consts.svh"

module ex_top
    import ex_data_pkg::*;
    import ex_op_pkg::*;
(
    input  logic      clk,
    input  logic      reset_i,
    input  logic      in_valid_i,
    input  alu_op_e   in_op_i,
    input  word_t     in_reg1_i,
    input  word_t     in_reg2_i,
    input  reg_addr_t in_wd_i,
    input  logic      in_wreg_i,
    input  logic      out_ready_i,
    output logic      in_ready_o,
    output logic      out_valid_o,
    output word_t     out_wdata_o,
    output reg_addr_t out_wd_o,
    output logic      out_wreg_o,
    output logic      out_ovf_o
);

    // issue register outputs
    logic      iss_valid;
    alu_op_e   iss_op;
    res_sel_e  iss_sel;
    word_t     iss_reg1;
    word_t     iss_reg2;
    reg_addr_t iss_wd;
    logic      iss_wreg;

    logic      mac_done;
    word_t     mul_lo;
    word_t     hi;
    word_t     lo;
    word_t     alu_res;
    logic      alu_ovf;
    logic      alu_wr_ok;
    logic      advance;   // issue -> output transfer

    ex_issue u_issue (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .in_op_i     (in_op_i),
        .in_reg1_i   (in_reg1_i),
        .in_reg2_i   (in_reg2_i),
        .in_wd_i     (in_wd_i),
        .in_wreg_i   (in_wreg_i),
        .advance_i   (advance),
        .in_ready_o  (in_ready_o),
        .iss_valid_o (iss_valid),
        .iss_op_o    (iss_op),
        .iss_sel_o   (iss_sel),
        .iss_reg1_o  (iss_reg1),
        .iss_reg2_o  (iss_reg2),
        .iss_wd_o    (iss_wd),
        .iss_wreg_o  (iss_wreg)
    );

    ex_alu u_alu (
        .op_i        (iss_op),
        .reg1_i      (iss_reg1),
        .reg2_i      (iss_reg2),
        .alu_res_o   (alu_res),
        .alu_ovf_o   (alu_ovf),
        .alu_wr_ok_o (alu_wr_ok)
    );

    ex_mult_acc u_mult_acc (
        .clk         (clk),
        .reset_i     (reset_i),
        .iss_valid_i (iss_valid),
        .op_i        (iss_op),
        .reg1_i      (iss_reg1),
        .reg2_i      (iss_reg2),
        .advance_i   (advance),
        .mac_done_o  (mac_done),
        .mul_lo_o    (mul_lo),
        .hi_o        (hi),
        .lo_o        (lo)
    );

    ex_writeback u_writeback (
        .clk         (clk),
        .reset_i     (reset_i),
        .iss_valid_i (iss_valid),
        .iss_sel_i   (iss_sel),
        .iss_wd_i    (iss_wd),
        .iss_wreg_i  (iss_wreg),
        .mac_done_i  (mac_done),
        .alu_res_i   (alu_res),
        .alu_ovf_i   (alu_ovf),
        .alu_wr_ok_i (alu_wr_ok),
        .mul_lo_i    (mul_lo),
        .hi_i        (hi),
        .lo_i        (lo),
        .out_ready_i (out_ready_i),
        .advance_o   (advance),
        .out_valid_o (out_valid_o),
        .out_wdata_o (out_wdata_o),
        .out_wd_o    (out_wd_o),
        .out_wreg_o  (out_wreg_o),
        .out_ovf_o   (out_ovf_o)
    );

endmodule

//--- test/ex_tb.sv
`timescale 1ns/1ps

module ex_tb
    import ex_data_pkg::*;
    import ex_op_pkg::*;
();

    localparam int MAX_VEC   = 64;
    localparam int VEC_WORDS = 8;     // words per line in the data file
    localparam int CYC_PER_VEC = 30;

    logic      clk;
    logic      reset_i;
    logic      in_valid_i;
    alu_op_e   in_op_i;
    word_t     in_reg1_i;
    word_t     in_reg2_i;
    reg_addr_t in_wd_i;
    logic      in_wreg_i;
    logic      out_ready_i;
    logic      in_ready_o;
    logic      out_valid_o;
    word_t     out_wdata_o;
    reg_addr_t out_wd_o;
    logic      out_wreg_o;
    logic      out_ovf_o;

    logic [31:0] vec_mem [0:MAX_VEC*VEC_WORDS-1];
    logic [16:0] lfsr_state;
    int          num_vec;
    int          rx_cnt;
    int          cycle_cnt;
    int          accept_cycle;
    logic        seen_accept;

    ex_top dut0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .in_op_i     (in_op_i),
        .in_reg1_i   (in_reg1_i),
        .in_reg2_i   (in_reg2_i),
        .in_wd_i     (in_wd_i),
        .in_wreg_i   (in_wreg_i),
        .out_ready_i (out_ready_i),
        .in_ready_o  (in_ready_o),
        .out_valid_o (out_valid_o),
        .out_wdata_o (out_wdata_o),
        .out_wd_o    (out_wd_o),
        .out_wreg_o  (out_wreg_o),
        .out_ovf_o   (out_ovf_o)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^17 + x^14 + 1, one step per bit
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    task automatic take_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic drive_vector(input int k);
        in_op_i    = alu_op_e'(vec_mem[k*VEC_WORDS][4:0]);
        in_reg1_i  = vec_mem[k*VEC_WORDS+1];
        in_reg2_i  = vec_mem[k*VEC_WORDS+2];
        in_wd_i    = vec_mem[k*VEC_WORDS+3][4:0];
        in_wreg_i  = vec_mem[k*VEC_WORDS+4][0];
        in_valid_i = 1'b1;
    endtask

    // fired tells whether the input handshake happened at this edge
    task automatic next_cycle(output logic fired);
        int r;
        @(negedge clk);
        fired = in_valid_i && in_ready_o;
        @(posedge clk);
        #2;
        if (rx_cnt == 0) begin
            out_ready_i = 1'b1;   // first result must see no back-pressure
        end else begin
            take_bits(2, r);
            out_ready_i = (r != 0);
        end
    endtask

    task automatic check_result(input int k);
        int b;
        b = k * VEC_WORDS;
        assert (k < num_vec)
            else abort_run($sformatf("an extra result came out after all %0d vectors", num_vec));
        assert (out_wdata_o == vec_mem[b+5])
            else abort_run($sformatf("[ERROR] %0t: vector %0d wdata %h, expected %h",
                                     $time, k, out_wdata_o, vec_mem[b+5]));
        assert (out_wd_o == vec_mem[b+3][4:0])
            else abort_run($sformatf("[ERROR] %0t: vector %0d wd %h, expected %h",
                                     $time, k, out_wd_o, vec_mem[b+3][4:0]));
        assert (out_wreg_o == vec_mem[b+6][0])
            else abort_run($sformatf("[ERROR] %0t: vector %0d wreg %b, expected %b",
                                     $time, k, out_wreg_o, vec_mem[b+6][0]));
        assert (out_ovf_o == vec_mem[b+7][0])
            else abort_run($sformatf("[ERROR] %0t: vector %0d ovf %b, expected %b",
                                     $time, k, out_ovf_o, vec_mem[b+7][0]));
        if (k == 0) begin
            assert (cycle_cnt == accept_cycle + 1)
                else abort_run($sformatf("[ERROR] %0t: first result %0d cycles after accept",
                                         $time, cycle_cnt - accept_cycle));
        end
    endtask

    // sample mid-cycle, handshakes complete at the next rising edge
    always @(negedge clk) begin
        if (!reset_i) begin
            cycle_cnt = cycle_cnt + 1;
            if (cycle_cnt > num_vec * CYC_PER_VEC) begin
                abort_run($sformatf("timeout, only %0d of %0d results after %0d cycles",
                                    rx_cnt, num_vec, cycle_cnt));
            end
            if (in_valid_i && in_ready_o && !seen_accept) begin
                seen_accept  = 1'b1;
                accept_cycle = cycle_cnt + 1;   // accepted at the coming edge
            end
            if (out_valid_o && out_ready_i) begin
                check_result(rx_cnt);
                rx_cnt = rx_cnt + 1;
            end
        end
    end

    initial begin
        int   k;
        int   g;
        logic fired;
        reset_i     = 1'b1;
        in_valid_i  = 1'b0;
        in_op_i     = OP_OR;
        in_reg1_i   = '0;
        in_reg2_i   = '0;
        in_wd_i     = '0;
        in_wreg_i   = 1'b0;
        out_ready_i = 1'b1;
        lfsr_state  = 17'd78877;
        rx_cnt      = 0;
        cycle_cnt   = 0;
        seen_accept = 1'b0;
        accept_cycle = 0;
        $readmemh("test/ex_testdata.txt", vec_mem);
        num_vec = 0;
        while (num_vec < MAX_VEC && vec_mem[num_vec*VEC_WORDS] != 32'hff) begin
            num_vec = num_vec + 1;   // ff opcode marks the end
        end
        if (num_vec == MAX_VEC) begin
            abort_run("test data file has no end marker");
        end
        repeat (8) @(posedge clk);
        #2;
        reset_i = 1'b0;
        for (k = 0; k < num_vec; k++) begin
            take_bits(2, g);
            in_valid_i = 1'b0;
            repeat ((g > 1) ? g - 1 : 0) next_cycle(fired);   // idle gap
            drive_vector(k);
            fired = 1'b0;
            while (!fired) begin
                next_cycle(fired);
            end
        end
        in_valid_i = 1'b0;
        while (rx_cnt < num_vec) begin
            next_cycle(fired);
        end
        repeat (4) next_cycle(fired);   // catch duplicates
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- test/ex_testdata.txt
// op reg1 reg2 wd wreg exp_wdata exp_wreg exp_ovf, all hex
// op is the opcode number 0..27, a line with op ff ends the list
00 0f0f00ff 00ff0f00 01 1 0fff0fff 1 0
01 0f0f00ff 00ff0f00 02 1 000f0000 1 0
02 0f0f00ff 00ff0f00 03 1 f000f000 1 0
03 a5a5a5a5 ffff0000 04 1 5a5aa5a5 1 0
04 00000004 12345678 05 1 23456780 1 0
05 00000008 80000010 06 1 00800000 1 0
06 00000004 80000010 07 1 f8000001 1 0
06 00000024 7ffffff0 08 1 07ffffff 1 0
07 00000005 00000007 09 1 0000000c 1 0
07 7fffffff 00000001 0a 1 80000000 0 1
08 7fffffff 00000001 0b 1 80000000 1 0
09 80000000 00000001 0c 1 7fffffff 0 1
0a 00000003 00000005 0d 1 fffffffe 1 0
0a 80000000 00000001 0e 1 7fffffff 1 0
0b ffffffff 00000001 0f 1 00000001 1 0
0c ffffffff 00000001 10 1 00000000 1 0
0d 00000000 00000000 11 1 00000020 1 0
0d 00010000 00000000 12 1 0000000f 1 0
0e ffffffff 00000000 13 1 00000020 1 0
0e fff00000 00000000 14 1 0000000c 1 0
0f deadbeef 00000000 15 1 deadbeef 1 0
0f cafef00d 00000001 16 1 cafef00d 0 0
10 12345678 00000002 17 1 12345678 1 0
10 87654321 00000000 18 1 87654321 0 0
12 ffffffff 00000002 00 0 00000000 0 0
18 00000000 00000000 19 1 ffffffff 1 0
19 00000000 00000000 1a 1 fffffffe 1 0
13 ffffffff 00000002 00 0 00000000 0 0
18 00000000 00000000 1b 1 00000001 1 0
19 00000000 00000000 1c 1 fffffffe 1 0
1a 00000005 00000000 00 0 00000000 0 0
19 00000000 00000000 1d 1 fffffffe 1 0
1b 00000010 00000000 00 0 00000000 0 0
18 00000000 00000000 1e 1 00000005 1 0
11 00001000 00001000 1f 1 01000000 1 0
18 00000000 00000000 01 1 00000005 1 0
14 00000003 00000004 00 0 00000000 0 0
19 00000000 00000000 02 1 0000001c 1 0
16 ffffffff 00000020 00 0 00000000 0 0
19 00000000 00000000 03 1 0000003c 1 0
15 ffffffff 00000002 00 0 00000000 0 0
18 00000000 00000000 04 1 00000007 1 0
19 00000000 00000000 05 1 0000003a 1 0
17 00000010 00000010 00 0 00000000 0 0
18 00000000 00000000 06 1 00000006 1 0
19 00000000 00000000 07 1 ffffff3a 1 0
ff 00000000 00000000 00 0 00000000 0 0

//--- vlog.f
+incdir+hw
hw/ex_data_pkg.sv
hw/ex_op_pkg.sv
hw/ex_issue.sv
hw/ex_alu.sv
hw/ex_mult_acc.sv
hw/ex_writeback.sv
hw/ex_top.sv
test/ex_tb.sv

//--- run_verilator.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ex_tb -f vlog.f -o ex_tb_sim

output=$(./obj_dir/ex_tb_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
else
    exit 1
fi
